// File: soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define DATA_W          32
`define ADDR_W          32
`define BE_W            4

// SRAM window, word addressed through byte addresses
`define SRAM_BASE       32'h8000_0000
`define SRAM_WORDS      256

// Host addresses in [REMAP_LO, REMAP_HI) get the top nibble replaced
`define REMAP_LO        32'h3000_0000
`define REMAP_HI        32'h8000_0000
`define REMAP_NIBBLE    4'h8

// Control word
`define CTRL_KEY        4'hA
`define IRQ_ADDR        32'hF000_0000
`define LA_W            128

`endif

// File: bus_pkg.sv
`include "soc_defines.svh"

package bus_pkg;

    // Wishbone classic, host to bridge
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [`BE_W-1:0]    sel;
        logic [`ADDR_W-1:0]  adr;
        logic [`DATA_W-1:0]  dat;
    } wb_req_t;

    // Wishbone classic, bridge to host
    typedef struct packed {
        logic                ack;
        logic [`DATA_W-1:0]  dat;
    } wb_rsp_t;

    // Internal request/grant bus, master side
    typedef struct packed {
        logic                req;
        logic                we;
        logic [`BE_W-1:0]    be;
        logic [`ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0]  wdata;
    } mem_req_t;

    // Internal bus, slave side
    typedef struct packed {
        logic                gnt;
        logic                rvalid;
        logic [`DATA_W-1:0]  rdata;
    } mem_rsp_t;

endpackage

// File: debug_pkg.sv
`include "soc_defines.svh"

package debug_pkg;

    typedef enum logic [2:0] {
        PROBE_HOST  = 3'd0,
        PROBE_LOCAL = 3'd1,
        PROBE_SRAM  = 3'd2,
        PROBE_FLAGS = 3'd3
    } probe_sel_e;

    // Low 15 bits of the control word, MSB first
    typedef struct packed {
        probe_sel_e  sel;
        logic [3:0]  reserved;
        logic [3:0]  en_key;
        logic [3:0]  soft_key;
    } la_ctrl_t;

    // Declared MSB first so addr lands in the lowest bits of the probe field
    typedef struct packed {
        logic [`DATA_W-1:0]  wdata;
        logic [`DATA_W-1:0]  rdata;
        logic                rvalid;
        logic [`BE_W-1:0]    be;
        logic                we;
        logic                gnt;
        logic                req;
        logic [`ADDR_W-1:0]  addr;
    } bus_probe_t;

endpackage

// File: wb_bridge.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module wb_bridge
    import bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       soft_rst_i,
    input  wb_req_t    host_wb_i,
    output wb_rsp_t    host_wb_o,
    output mem_req_t   mem_req_o,
    input  mem_rsp_t   mem_rsp_i,
    output logic [1:0] state_o
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_WAIT = 2'd2
    } state_e;

    state_e              state_q;
    logic                ack_q;
    logic                start;
    logic [`ADDR_W-1:0]  addr_remap;

    // Latched transaction
    logic                we_q;
    logic [`BE_W-1:0]    be_q;
    logic [`ADDR_W-1:0]  addr_q;
    logic [`DATA_W-1:0]  wdata_q;
    logic [`DATA_W-1:0]  rdata_q;

    always_comb begin
        if (host_wb_i.adr >= `REMAP_LO && host_wb_i.adr < `REMAP_HI) begin
            addr_remap = {`REMAP_NIBBLE, host_wb_i.adr[`ADDR_W-5:0]};
        end else begin
            addr_remap = host_wb_i.adr;
        end
    end

    // stb is still high in the ack cycle, so that cycle must not start a new one
    assign start = host_wb_i.cyc && host_wb_i.stb && !ack_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
        end else if (soft_rst_i) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_rsp_i.gnt) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (mem_rsp_i.rvalid) begin
                        ack_q   <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start) begin
            we_q    <= host_wb_i.we;
            be_q    <= host_wb_i.sel;
            addr_q  <= addr_remap;
            wdata_q <= host_wb_i.dat;
        end
        if (state_q == ST_WAIT && mem_rsp_i.rvalid) begin
            rdata_q <= mem_rsp_i.rdata;
        end
    end

    always_comb begin
        mem_req_o.req   = (state_q == ST_REQ);
        mem_req_o.we    = we_q;
        mem_req_o.be    = be_q;
        mem_req_o.addr  = addr_q;
        mem_req_o.wdata = wdata_q;
    end

    assign host_wb_o.ack = ack_q;
    assign host_wb_o.dat = rdata_q;
    assign state_o       = state_q;

    // An ack always answers a strobe the host is still holding
    ack_needs_stb: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $rose(host_wb_o.ack) |-> host_wb_i.stb
    );

endmodule

// File: sram_arbiter.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module sram_arbiter
    import bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     soft_rst_i,
    input  logic     host_en_i,
    input  mem_req_t host_req_i,
    output mem_rsp_t host_rsp_o,
    input  mem_req_t local_req_i,
    output mem_rsp_t local_rsp_o,
    output mem_req_t sram_req_o,
    input  mem_rsp_t sram_rsp_i
);

    logic host_req_v;
    logic host_gnt;
    logic local_gnt;
    // Set when the transaction granted last cycle belongs to the host
    logic owner_host_q;

    // Host request only counts while the host is enabled
    assign host_req_v = host_req_i.req && host_en_i;

    always_comb begin
        if (host_req_v) begin
            sram_req_o = host_req_i;
        end else begin
            sram_req_o = local_req_i;
        end
    end

    // Local master keeps req high without gnt while the host wins
    assign host_gnt  = host_req_v && sram_rsp_i.gnt;
    assign local_gnt = !host_req_v && local_req_i.req && sram_rsp_i.gnt;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_host_q <= 1'b0;
        end else if (soft_rst_i) begin
            owner_host_q <= 1'b0;
        end else begin
            owner_host_q <= host_gnt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response routing
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        host_rsp_o.gnt    = host_gnt;
        host_rsp_o.rvalid = sram_rsp_i.rvalid && owner_host_q;
        host_rsp_o.rdata  = sram_rsp_i.rdata;

        local_rsp_o.gnt    = local_gnt;
        local_rsp_o.rvalid = sram_rsp_i.rvalid && !owner_host_q;
        local_rsp_o.rdata  = sram_rsp_i.rdata;
    end

    // A slave grant reaches exactly one master
    one_grant: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        sram_rsp_i.gnt |-> $onehot({host_rsp_o.gnt, local_rsp_o.gnt})
    );

endmodule

// File: sram_bank.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module sram_bank
    import bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     soft_rst_i,
    input  mem_req_t req_i,
    output mem_rsp_t rsp_o,
    output logic     illegal_o
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam logic [`ADDR_W-1:0] SRAM_END = `SRAM_BASE + (`SRAM_WORDS * (`DATA_W / 8));

    logic [`DATA_W-1:0] mem [`SRAM_WORDS];

    logic               in_range;
    logic [IDX_W-1:0]   idx;
    logic               rvalid_q;
    logic               illegal_q;
    logic [`DATA_W-1:0] rdata_q;

    assign in_range = (req_i.addr >= `SRAM_BASE) && (req_i.addr < SRAM_END);
    assign idx      = req_i.addr[IDX_W+1:2];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else if (soft_rst_i) begin
            rvalid_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            rvalid_q  <= req_i.req;
            illegal_q <= req_i.req && !in_range;
        end
    end

    // Byte-lane writes that skip out-of-window addresses
    always_ff @(posedge clk_i) begin
        if (req_i.req && req_i.we && in_range && !soft_rst_i) begin
            for (int b = 0; b < `BE_W; b++) begin
                if (req_i.be[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.req) begin
            rdata_q <= (in_range && !req_i.we) ? mem[idx] : '0;
        end
    end

    always_comb begin
        rsp_o.gnt    = req_i.req;
        rsp_o.rvalid = rvalid_q;
        rsp_o.rdata  = rdata_q;
    end

    assign illegal_o = illegal_q;

    // rvalid answers a granted request whose direction and address were known
    rvalid_after_gnt: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rsp_o.rvalid |-> $past(rsp_o.gnt && !soft_rst_i &&
                               !$isunknown({req_i.we, req_i.addr}))
    );

endmodule

// File: debug_probe.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module debug_probe
    import bus_pkg::*, debug_pkg::*;
(
    input  logic [`LA_W-1:0] la_data_i,
    output logic [`LA_W-1:0] la_data_o,
    output logic             soft_rst_o,
    output logic             host_en_o,
    input  bus_probe_t       host_probe_i,
    input  bus_probe_t       local_probe_i,
    input  bus_probe_t       sram_probe_i,
    input  logic [1:0]       bridge_state_i,
    input  logic             illegal_i,
    output logic [2:0]       irq_o
);

    localparam int PROBE_LSB = 16;
    localparam int PROBE_MSB = PROBE_LSB + $bits(bus_probe_t) - 1;

    la_ctrl_t ctrl;
    mem_req_t local_req;

    assign ctrl = la_ctrl_t'(la_data_i[$bits(la_ctrl_t)-1:0]);

    // Keyed fields, anything but the key leaves them inactive
    assign soft_rst_o = (ctrl.soft_key == `CTRL_KEY);
    assign host_en_o  = (ctrl.en_key == `CTRL_KEY);

    //////////////////////////////////////////////////////////////////////
    // Probe multiplexer
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        la_data_o = '1;
        case (ctrl.sel)
            PROBE_HOST:  la_data_o[PROBE_MSB:PROBE_LSB] = host_probe_i;
            PROBE_LOCAL: la_data_o[PROBE_MSB:PROBE_LSB] = local_probe_i;
            PROBE_SRAM:  la_data_o[PROBE_MSB:PROBE_LSB] = sram_probe_i;
            PROBE_FLAGS: begin
                la_data_o[PROBE_MSB:PROBE_LSB]     = '0;
                la_data_o[PROBE_LSB]               = illegal_i;
                la_data_o[PROBE_LSB+2:PROBE_LSB+1] = bridge_state_i;
            end
            default: ;
        endcase
    end

    // Local master request seen as a bus request for the IRQ decode
    always_comb begin
        local_req.req   = local_probe_i.req;
        local_req.we    = local_probe_i.we;
        local_req.be    = local_probe_i.be;
        local_req.addr  = local_probe_i.addr;
        local_req.wdata = local_probe_i.wdata;
    end

    // Software interrupt wins over the illegal-access flag
    always_comb begin
        if (local_req.req && local_req.we && local_req.addr == `IRQ_ADDR) begin
            irq_o = {1'b0, local_req.wdata[1:0]};
        end else begin
            irq_o = {illegal_i, 2'b00};
        end
    end

endmodule

// File: soc_top.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_top
    import bus_pkg::*, debug_pkg::*;
(
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  wb_req_t          host_wb_i,
    output wb_rsp_t          host_wb_o,
    input  mem_req_t         local_req_i,
    output mem_rsp_t         local_rsp_o,
    input  logic [`LA_W-1:0] la_data_i,
    output logic [`LA_W-1:0] la_data_o,
    output logic [2:0]       irq_o
);

    logic       soft_rst;
    logic       host_en;
    logic       illegal;
    logic [1:0] bridge_state;

    mem_req_t   host_mem;
    mem_rsp_t   host_mem_rsp;
    mem_req_t   sram_req;
    mem_rsp_t   sram_rsp;

    bus_probe_t host_probe;
    bus_probe_t local_probe;
    bus_probe_t sram_probe;

    wb_bridge u_wb_bridge (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .soft_rst_i (soft_rst),
        .host_wb_i  (host_wb_i),
        .host_wb_o  (host_wb_o),
        .mem_req_o  (host_mem),
        .mem_rsp_i  (host_mem_rsp),
        .state_o    (bridge_state)
    );

    sram_arbiter u_sram_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .soft_rst_i  (soft_rst),
        .host_en_i   (host_en),
        .host_req_i  (host_mem),
        .host_rsp_o  (host_mem_rsp),
        .local_req_i (local_req_i),
        .local_rsp_o (local_rsp_o),
        .sram_req_o  (sram_req),
        .sram_rsp_i  (sram_rsp)
    );

    sram_bank u_sram_bank (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .soft_rst_i (soft_rst),
        .req_i      (sram_req),
        .rsp_o      (sram_rsp),
        .illegal_o  (illegal)
    );

    //////////////////////////////////////////////////////////////////////
    // Probe records
    //////////////////////////////////////////////////////////////////////

    assign host_probe = '{addr: host_mem.addr, req: host_mem.req, gnt: host_mem_rsp.gnt,
                          we: host_mem.we, be: host_mem.be, rvalid: host_mem_rsp.rvalid,
                          rdata: host_mem_rsp.rdata, wdata: host_mem.wdata};

    assign local_probe = '{addr: local_req_i.addr, req: local_req_i.req,
                           gnt: local_rsp_o.gnt, we: local_req_i.we, be: local_req_i.be,
                           rvalid: local_rsp_o.rvalid, rdata: local_rsp_o.rdata,
                           wdata: local_req_i.wdata};

    assign sram_probe = '{addr: sram_req.addr, req: sram_req.req, gnt: sram_rsp.gnt,
                          we: sram_req.we, be: sram_req.be, rvalid: sram_rsp.rvalid,
                          rdata: sram_rsp.rdata, wdata: sram_req.wdata};

    debug_probe u_debug_probe (
        .la_data_i      (la_data_i),
        .la_data_o      (la_data_o),
        .soft_rst_o     (soft_rst),
        .host_en_o      (host_en),
        .host_probe_i   (host_probe),
        .local_probe_i  (local_probe),
        .sram_probe_i   (sram_probe),
        .bridge_state_i (bridge_state),
        .illegal_i      (illegal),
        .irq_o          (irq_o)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS    = 20.0,
    parameter int  RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Release just after an edge so no flop sees it mid-sample
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;
    end

endmodule

// File: tb_soc.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc
    import bus_pkg::*, debug_pkg::*;
();

    // Roughly 30 transactions of under 10 cycles each plus idle waits
    localparam int MAX_CYCLES = 2000;
    localparam int PROBE_LSB  = 16;
    localparam int IDX_W      = $clog2(`SRAM_WORDS);

    logic             clk;
    logic             arst_n;
    wb_req_t          host_wb;
    wb_rsp_t          host_rsp;
    mem_req_t         local_req;
    mem_rsp_t         local_rsp;
    logic [`LA_W-1:0] la_in;
    logic [`LA_W-1:0] la_out;
    logic [2:0]       irq;

    logic [15:0]        lfsr_q;
    logic [`DATA_W-1:0] model [`SRAM_WORDS];
    int                 cycles;

    tb_clock #(.PERIOD_NS(20.0), .RESET_CYCLES(8)) u_clock (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    soc_top dut (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .host_wb_i   (host_wb),
        .host_wb_o   (host_rsp),
        .local_req_i (local_req),
        .local_rsp_o (local_rsp),
        .la_data_i   (la_in),
        .la_data_o   (la_out),
        .irq_o       (irq)
    );

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [`DATA_W-1:0] got,
                                input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic compare_wb(input string name, input wb_rsp_t got, input wb_rsp_t exp,
                              input logic check_dat);
        if (got.ack !== exp.ack || (check_dat && got.dat !== exp.dat)) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic compare_rsp(input string name, input mem_rsp_t got, input mem_rsp_t exp,
                               input logic check_rdata);
        if (got.gnt !== exp.gnt || got.rvalid !== exp.rvalid ||
            (check_rdata && got.rdata !== exp.rdata)) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic compare_irq(input string name, input logic [2:0] got,
                               input logic [2:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
                                      $time, name, got, exp));
        end
    endtask

    task automatic compare_la(input string name, input logic [`LA_W-1:0] got,
                              input logic [`LA_W-1:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                                      $time, name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    //////////////////////////////////////////////////////////////////////

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_word(input int nbits);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w      = {w[30:0], lfsr_q[0]};
        end
        return w;
    endfunction

    function automatic logic [`ADDR_W-1:0] remap_addr(input logic [`ADDR_W-1:0] adr);
        if (adr >= `REMAP_LO && adr < `REMAP_HI) begin
            return {`REMAP_NIBBLE, adr[`ADDR_W-5:0]};
        end
        return adr;
    endfunction

    function automatic logic in_window(input logic [`ADDR_W-1:0] adr);
        return adr >= `SRAM_BASE && adr < `SRAM_BASE + (`SRAM_WORDS * 4);
    endfunction

    function automatic logic [`DATA_W-1:0] expected_word(input logic [`ADDR_W-1:0] adr);
        if (!in_window(adr)) begin
            return '0;
        end
        return model[adr[IDX_W+1:2]];
    endfunction

    task automatic model_write(input logic [`ADDR_W-1:0] adr, input logic [3:0] sel,
                               input logic [`DATA_W-1:0] dat);
        logic [`DATA_W-1:0] word;
        word = model[adr[IDX_W+1:2]];
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                word[8*b +: 8] = dat[8*b +: 8];
            end
        end
        model[adr[IDX_W+1:2]] = word;
    endtask

    task automatic next_drive();
        @(posedge clk);
        #1;
    endtask

    task automatic set_ctrl(input logic [3:0] soft_key, input logic [3:0] en_key,
                            input probe_sel_e sel);
        la_ctrl_t c;
        c.soft_key = soft_key;
        c.en_key   = en_key;
        c.reserved = 4'h0;
        c.sel      = sel;
        la_in      = '0;
        la_in[$bits(la_ctrl_t)-1:0] = c;
    endtask

    task automatic wb_drive(input logic we, input logic [3:0] sel,
                            input logic [`ADDR_W-1:0] adr, input logic [`DATA_W-1:0] dat);
        host_wb = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
    endtask

    // Counts cycles to ack and keeps the strobe low for the cycle after it
    task automatic wb_wait_ack(output int lat, output wb_rsp_t rsp);
        wb_rsp_t idle;
        idle = '{ack: 1'b0, dat: '0};
        lat  = 0;
        @(negedge clk);
        while (!host_rsp.ack) begin
            lat++;
            @(negedge clk);
        end
        rsp = host_rsp;
        next_drive();
        host_wb = '0;
        @(negedge clk);
        compare_wb("host_wb_o", host_rsp, idle, 1'b0);
        next_drive();
    endtask

    task automatic expect_no_ack(input int n);
        repeat (n) begin
            @(negedge clk);
            if (host_rsp.ack) begin
                stop_with_error("host ack arrived while the host was disabled");
            end
        end
    endtask

    task automatic check_latency(input int lat);
        if (lat != 3) begin
            stop_with_error($sformatf("host ack came %0d cycles after stb instead of 3", lat));
        end
    endtask

    task automatic wb_write(input logic [3:0] sel, input logic [`ADDR_W-1:0] adr,
                            input logic [`DATA_W-1:0] dat);
        int      lat;
        wb_rsp_t rsp;
        wb_drive(1'b1, sel, adr, dat);
        wb_wait_ack(lat, rsp);
        check_latency(lat);
        if (in_window(remap_addr(adr))) begin
            model_write(remap_addr(adr), sel, dat);
        end
    endtask

    task automatic wb_read(input logic [`ADDR_W-1:0] adr);
        int      lat;
        wb_rsp_t rsp;
        wb_rsp_t exp;
        wb_drive(1'b0, 4'hF, adr, '0);
        wb_wait_ack(lat, rsp);
        check_latency(lat);
        exp = '{ack: 1'b1, dat: expected_word(remap_addr(adr))};
        compare_wb("host_wb_o", rsp, exp, 1'b1);
    endtask

    task automatic local_access(input logic we, input logic [3:0] be,
                                input logic [`ADDR_W-1:0] adr,
                                input logic [`DATA_W-1:0] dat, input int exp_waits,
                                input logic check_irq, input logic [2:0] irq_req,
                                input logic [2:0] irq_rsp);
        int       waits;
        mem_rsp_t exp;
        waits     = 0;
        exp       = '{gnt: 1'b0, rvalid: 1'b1, rdata: expected_word(adr)};
        local_req = '{req: 1'b1, we: we, be: be, addr: adr, wdata: dat};
        @(negedge clk);
        if (check_irq) begin
            compare_irq("irq_o", irq, irq_req);
        end
        while (!local_rsp.gnt) begin
            waits++;
            @(negedge clk);
        end
        if (waits != exp_waits) begin
            stop_with_error($sformatf("local grant came after %0d cycles instead of %0d",
                                      waits, exp_waits));
        end
        next_drive();
        local_req = '0;
        @(negedge clk);
        compare_rsp("local_rsp_o", local_rsp, exp, !we);
        if (check_irq) begin
            compare_irq("irq_o", irq, irq_rsp);
        end
        if (we && in_window(adr)) begin
            model_write(adr, be, dat);
        end
        next_drive();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_host_rw();
        logic [`ADDR_W-1:0] offs [4];
        logic [3:0]         sels [4];
        offs = '{32'h010, 32'h024, 32'h100, 32'h3FC};
        sels = '{4'b0011, 4'b1000, 4'b0110, 4'b0101};
        foreach (offs[i]) begin
            wb_write(4'hF, `SRAM_BASE + offs[i], rand_word(32));
            wb_write(sels[i], `SRAM_BASE + offs[i], rand_word(32));
            wb_read(`SRAM_BASE + offs[i]);
        end
    endtask

    task automatic test_remap();
        wb_write(4'hF, 32'h3000_0040, rand_word(32));
        local_access(1'b0, 4'hF, 32'h8000_0040, '0, 0, 1'b0, 3'b000, 3'b000);
    endtask

    task automatic test_host_disabled();
        logic [`ADDR_W-1:0] adr;
        logic [`DATA_W-1:0] dat;
        int                 lat;
        wb_rsp_t            rsp;
        adr = `SRAM_BASE + 32'h0C0;
        dat = rand_word(32);
        set_ctrl(4'h0, 4'h0, PROBE_HOST);
        wb_drive(1'b1, 4'hF, adr, dat);
        expect_no_ack(10);
        next_drive();
        set_ctrl(4'h0, `CTRL_KEY, PROBE_HOST);
        wb_wait_ack(lat, rsp);
        model_write(adr, 4'hF, dat);
        wb_read(adr);
    endtask

    // Host bridge raises req one cycle after stb, so local starts a cycle later
    task automatic test_contention();
        fork
            wb_write(4'hF, `SRAM_BASE + 32'h200, rand_word(32));
            begin
                next_drive();
                local_access(1'b0, 4'hF, `SRAM_BASE + 32'h024, '0, 1, 1'b0, 3'b000, 3'b000);
            end
        join
        wb_read(`SRAM_BASE + 32'h200);
    endtask

    task automatic test_irq();
        logic [`DATA_W-1:0] dat;
        dat = rand_word(30);
        dat = {dat[`DATA_W-3:0], 2'b10};
        local_access(1'b0, 4'hF, 32'h0000_1000, '0, 0, 1'b1, 3'b000, 3'b100);
        local_access(1'b1, 4'hF, `IRQ_ADDR, dat, 0, 1'b1, 3'b010, 3'b100);
    endtask

    task automatic test_probe_and_soft_reset();
        bus_probe_t         probe;
        logic [`ADDR_W-1:0] adr;
        logic [`ADDR_W-1:0] old_adr;
        logic [`LA_W-1:0]   ones;
        adr     = `SRAM_BASE + 32'h080;
        old_adr = `SRAM_BASE + 32'h010;
        ones    = '1;
        set_ctrl(4'h0, `CTRL_KEY, PROBE_SRAM);
        local_req = '{req: 1'b1, we: 1'b0, be: 4'hF, addr: adr, wdata: '0};
        @(negedge clk);
        probe = la_out[PROBE_LSB +: $bits(bus_probe_t)];
        compare_word("sram probe addr", probe.addr, adr);
        next_drive();
        local_req = '0;
        for (int s = 4; s < 8; s++) begin
            next_drive();
            set_ctrl(4'h0, `CTRL_KEY, probe_sel_e'(s));
            @(negedge clk);
            compare_la("la_data_o", la_out, ones);
        end
        next_drive();
        // The soft key clears a stuck host write before it can land
        set_ctrl(4'h0, 4'h0, PROBE_HOST);
        wb_drive(1'b1, 4'hF, old_adr, rand_word(32));
        expect_no_ack(4);
        next_drive();
        set_ctrl(`CTRL_KEY, 4'h0, PROBE_HOST);
        next_drive();
        host_wb = '0;
        next_drive();
        set_ctrl(4'h0, `CTRL_KEY, PROBE_HOST);
        next_drive();
        wb_write(4'hF, adr, rand_word(32));
        wb_read(old_adr);
        wb_read(adr);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        host_wb   = '0;
        local_req = '0;
        la_in     = '0;
        lfsr_q    = 16'd37;
        @(posedge arst_n);
        next_drive();
        set_ctrl(4'h0, `CTRL_KEY, PROBE_HOST);
        next_drive();
        test_host_rw();
        test_remap();
        test_host_disabled();
        test_contention();
        test_irq();
        test_probe_and_soft_reset();
        $display("No errors");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        stop_with_error($sformatf("timeout, tests still running after %0d cycles",
                                  MAX_CYCLES));
    end

endmodule

// File: src.f
+incdir+.
bus_pkg.sv
debug_pkg.sv
wb_bridge.sv
sram_arbiter.sv
sram_bank.sv
debug_probe.sv
soc_top.sv
tb_clock.sv
tb_soc.sv
